/* project.f */
+incdir+source
source/gpu_pkg.sv
source/gpu_counters.sv
source/gpu_vram.sv
source/gpu_pixel_pipe.sv
source/gpu.sv
tests/gpu_clock_gen.sv
tests/gpu_tb.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f project.f --top-module gpu_tb --Mdir obj_dir -o gpu_tb_sim
	out="$$(./obj_dir/gpu_tb_sim 2>&1)"; \
		echo "$$out"; \
		echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf obj_dir

/* tests/gpu_tb.sv */
//####################################################################
// testbench for the tile background generator: fills VRAM through
// the host port in frame 0, then checks syncs on every clock and a
// table of probe positions in frame 1 against a reference model
//####################################################################
`timescale 1ns/1ps
`default_nettype none

`include "gpu_cfg.svh"

module gpu_tb;

    localparam int RESET_CYCLES   = 4;
    localparam int LATENCY        = `GPU_PIPE_LATENCY;
    localparam int FRAME_CYCLES   = `GPU_CLOCKS_PER_LINE * `GPU_LINES_PER_FRAME;
    localparam int VRAM_BYTES     = `GPU_PMB_BYTES + `GPU_NTBL_BYTES;
    localparam int HOST_ADDRESSES = 1 << `VRAM_ADDR_WIDTH;
    localparam int LAST_CYCLE     = 2 * FRAME_CYCLES + LATENCY - 1;
    localparam int TIMEOUT_CYCLES = 2 * FRAME_CYCLES + 2000;

    logic                        clk;
    logic                        rst;
    logic [1:0]                  r;
    logic [1:0]                  g;
    logic [1:0]                  b;
    logic                        hsync;
    logic                        vsync;
    logic [7:0]                  data;
    logic [`VRAM_ADDR_WIDTH-1:0] address;
    logic                        cs;

    // copy of both memories in host address order
    logic [7:0] vram_copy [VRAM_BYTES];

    int    probe_hc[$];
    int    probe_vc[$];
    bit    probe_from_model[$];
    int    probe_tile[$];
    string probe_label[$];

    int cycle_count = 0;

    gpu_clock_gen #(
        .PERIOD_NS    (8),
        .RESET_CYCLES (RESET_CYCLES)
    ) clock_gen (
        .clk (clk),
        .rst (rst)
    );

    gpu_m gpu_m_inst (
        .clk     (clk),
        .rst     (rst),
        .r       (r),
        .g       (g),
        .b       (b),
        .hsync   (hsync),
        .vsync   (vsync),
        .data    (data),
        .address (address),
        .cs      (cs)
    );

    function automatic logic [31:0] next_random(input logic [31:0] state);
        logic [31:0] x;
        x = state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic int tile_of(input int hc, input int vc);
        return ((vc / 2) / 8) * 32 + hc / 8;
    endfunction

    function automatic bit in_picture(input int hc, input int vc);
        return (hc < `GPU_H_VISIBLE) && (vc < `GPU_V_VISIBLE);
    endfunction

    // returns {r, g, b} for a screen position from the memory copy
    function automatic logic [5:0] expected_rgb(input int hc, input int vc);
        int          x;
        int          ty;
        int          addr;
        logic [7:0]  tile;
        logic [7:0]  colors;
        logic [15:0] line_bits;
        logic [1:0]  p;
        logic [2:0]  col;
        if (!in_picture(hc, vc))
            return 6'd0;
        x    = hc % 8;
        ty   = (vc / 2) % 8;
        tile = vram_copy[`GPU_NTBL_BASE + tile_of(hc, vc)];
        if (tile[5])
            ty = 7 - ty;
        if (tile[6])
            x = 7 - x;
        addr      = `GPU_PMB_BASE + int'(tile[4:0]) * 16 + ty * 2;
        line_bits = {vram_copy[addr], vram_copy[addr + 1]};
        p         = 2'(line_bits >> (14 - 2 * x));
        colors    = vram_copy[`GPU_NTBL_BASE + `GPU_NTBL_COLORS_INDEX];
        col       = tile[7] ? colors[5:3] : colors[2:0];
        return {col[0] ? p : 2'b00, col[1] ? p : 2'b00, col[2] ? p : 2'b00};
    endfunction

    task automatic check_value(input string label, input int expected, input int actual);
        if (expected != actual) begin
            $display("MISMATCH at %0d ns: %s expected 'h%0h got 'h%0h",
                     $time, label, expected, actual);
            $display("*** FAILED ***");
            $fatal(1, "stopping at first error");
        end
    endtask

    task automatic check_idle(input string label);
        check_value({label, " rgb"}, 0, int'({r, g, b}));
        check_value({label, " hsync"}, 1, int'(hsync));
        check_value({label, " vsync"}, 1, int'(vsync));
    endtask

    task automatic check_syncs(input int hc, input int vc);
        bit exp_h;
        bit exp_v;
        exp_h = !(hc >= `GPU_H_SYNC_START && hc < `GPU_H_SYNC_END);
        exp_v = !(vc >= `GPU_V_SYNC_START && vc < `GPU_V_SYNC_END);
        check_value("hsync level", int'(exp_h), int'(hsync));
        check_value("vsync level", int'(exp_v), int'(vsync));
    endtask

    task automatic add_probe(input int hc, input int vc, input string label,
                             input bit from_model, input int tile);
        probe_hc.push_back(hc);
        probe_vc.push_back(vc);
        probe_label.push_back(label);
        probe_from_model.push_back(from_model);
        probe_tile.push_back(tile);
    endtask

    // tile byte is {colour select, hflip, vflip, pattern}
    // probes listed in raster order
    task automatic build_probe_table();
        add_probe(3,   0,   "r0c0 plain",               1'b1, 'h03);
        add_probe(100, 0,   "r0c12 high colour",        1'b1, 'h85);
        add_probe(300, 0,   "border on line 0",         1'b0, 0);
        add_probe(3,   1,   "r0c0 doubled line",        1'b1, 'h03);
        add_probe(255, 1,   "r0c31 last column",        1'b1, 'h1f);
        add_probe(340, 1,   "inside hsync window",      1'b0, 0);
        add_probe(66,  37,  "r2c8 hflip x2",            1'b1, 'h47);
        add_probe(69,  37,  "r2c8 hflip x5",            1'b1, 'h47);
        add_probe(66,  38,  "r2c8 hflip next line",     1'b1, 'h47);
        add_probe(130, 121, "r7c16 vflip",              1'b1, 'h2a);
        add_probe(201, 200, "r12c25 both flips",        1'b1, 'he9);
        add_probe(201, 201, "r12c25 both flips pair",   1'b1, 'he9);
        add_probe(10,  250, "r15c1 blank pattern",      1'b1, 'h00);
        add_probe(40,  250, "r15c5 low colour",         1'b1, 'h11);
        add_probe(48,  250, "r15c6 high colour",        1'b1, 'h91);
        add_probe(319, 400, "last border clock",        1'b0, 0);
        add_probe(250, 479, "r29c31 last row hflip",    1'b1, 'h56);
        add_probe(256, 479, "first border clock",       1'b0, 0);
        add_probe(0,   480, "first blank line",         1'b0, 0);
        add_probe(128, 480, "blank line middle",        1'b0, 0);
        add_probe(10,  490, "vsync line",               1'b0, 0);
        add_probe(399, 524, "last clock of frame",      1'b0, 0);
    endtask

    task automatic fill_memory_copy();
        logic [31:0] rng;
        int          i;
        int          k;
        rng = 32'd46;
        for (i = 0; i < VRAM_BYTES; i++) begin
            rng          = next_random(rng);
            vram_copy[i] = rng[7:0];
        end
        // pattern 0 left blank for the pixel-0 probes
        for (i = 0; i < 16; i++)
            vram_copy[`GPU_PMB_BASE + i] = 8'h00;
        vram_copy[`GPU_NTBL_BASE + `GPU_NTBL_COLORS_INDEX] = 8'h15;
        for (k = 0; k < probe_hc.size(); k++) begin
            if (probe_from_model[k])
                vram_copy[`GPU_NTBL_BASE + tile_of(probe_hc[k], probe_vc[k])] =
                    8'(probe_tile[k]);
        end
    endtask

    task automatic drive_write(input int t);
        if (t < VRAM_BYTES) begin
            cs      = 1'b1;
            address = `VRAM_ADDR_WIDTH'(t);
            data    = vram_copy[t];
        end else if (t < HOST_ADDRESSES) begin
            // unmapped tail of the address space must leave both arrays alone
            cs      = 1'b1;
            address = `VRAM_ADDR_WIDTH'(t);
            data    = 8'hff;
        end else begin
            cs      = 1'b0;
            address = '0;
            data    = 8'h00;
        end
    endtask

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("run timed out after %0d clock cycles", cycle_count);
            $display("*** FAILED ***");
            $fatal(1, "simulation limit reached");
        end
    end

    initial begin : stimulus
        int         t;
        int         pos;
        int         frame;
        int         hc_pos;
        int         vc_pos;
        int         next_probe;
        logic [5:0] expected;
        data       = 8'h00;
        address    = '0;
        cs         = 1'b0;
        next_probe = 0;
        build_probe_table();
        fill_memory_copy();
        repeat (RESET_CYCLES - 1) begin
            @(posedge clk);
            #1;
            check_idle("during reset");
        end
        // cycle t is the clock after rising edge RESET_CYCLES + t
        for (t = 0; t <= LAST_CYCLE; t++) begin
            @(posedge clk);
            #1;
            drive_write(t);
            if (t < LATENCY) begin
                check_idle("pipeline fill");
            end else begin
                pos    = t - LATENCY;
                frame  = pos / FRAME_CYCLES;
                pos    = pos % FRAME_CYCLES;
                hc_pos = pos % `GPU_CLOCKS_PER_LINE;
                vc_pos = pos / `GPU_CLOCKS_PER_LINE;
                check_syncs(hc_pos, vc_pos);
                if (frame == 1) begin
                    if (!in_picture(hc_pos, vc_pos))
                        check_value("blanking black", 0, int'({r, g, b}));
                    if (next_probe < probe_hc.size() && probe_hc[next_probe] == hc_pos &&
                        probe_vc[next_probe] == vc_pos) begin
                        if (probe_from_model[next_probe])
                            expected = expected_rgb(hc_pos, vc_pos);
                        else
                            expected = 6'd0;
                        check_value(probe_label[next_probe], int'(expected), int'({r, g, b}));
                        next_probe++;
                    end
                end
            end
        end
        if (next_probe == probe_hc.size()) begin
            $display("*** PASSED ***");
            $finish;
        end else begin
            $display("only %0d of %0d probe positions were reached",
                     next_probe, probe_hc.size());
            $display("*** FAILED ***");
            $fatal(1, "probe table not completed");
        end
    end

endmodule

`default_nettype wire

/* tests/gpu_clock_gen.sv */
//####################################################################
// testbench clock and reset source for the tile video generator
// clk toggles every half period; rst is high for the first
// RESET_CYCLES rising edges and drops 1 ns after the last of them
//####################################################################
`timescale 1ns/1ps
`default_nettype none

module gpu_clock_gen #(
    parameter int PERIOD_NS    = 8,
    parameter int RESET_CYCLES = 4
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
    end

endmodule

`default_nettype wire

/* source/gpu.sv */
//####################################################################
// tile background video generator, top level
// host fills pattern memory and nametable through data/address/cs;
// the raster comes out as 2-bit r, g, b with active-low syncs
//####################################################################
`timescale 1ns/1ps
`default_nettype none

`include "gpu_cfg.svh"

module gpu_m
    import gpu_pkg::*;
(
    // 12.5875 MHz pixel clock
    input  wire logic                        clk,
    input  wire logic                        rst,
    output logic [1:0]                       r,
    output logic [1:0]                       g,
    output logic [1:0]                       b,
    output logic                             hsync,
    output logic                             vsync,
    input  wire logic [7:0]                  data,
    input  wire logic [`VRAM_ADDR_WIDTH-1:0] address,
    input  wire logic                        cs
);

    logic [8:0]    hc;
    logic [9:0]    vc;
    raster_phase_e h_phase;
    raster_phase_e v_phase;
    logic          hsync_raw;
    logic          vsync_raw;
    logic [9:0]    tile_index;
    logic [7:0]    tile_byte;
    logic [8:0]    pattern_line_addr;
    logic [15:0]   pattern_line;
    logic [7:0]    colors;

    gpu_counters_m gpu_counters (
        .clk       (clk),
        .rst       (rst),
        .hc        (hc),
        .vc        (vc),
        .h_phase   (h_phase),
        .v_phase   (v_phase),
        .hsync_raw (hsync_raw),
        .vsync_raw (vsync_raw)
    );

    gpu_vram_m gpu_vram (
        .clk               (clk),
        .data              (data),
        .address           (address),
        .cs                (cs),
        .tile_index        (tile_index),
        .tile_byte         (tile_byte),
        .pattern_line_addr (pattern_line_addr),
        .pattern_line      (pattern_line),
        .colors            (colors)
    );

    gpu_pixel_pipe_m gpu_pixel_pipe (
        .clk               (clk),
        .rst               (rst),
        .hc                (hc),
        .vc                (vc),
        .h_phase           (h_phase),
        .v_phase           (v_phase),
        .hsync_raw         (hsync_raw),
        .vsync_raw         (vsync_raw),
        .tile_index        (tile_index),
        .tile_byte         (tile_byte),
        .pattern_line_addr (pattern_line_addr),
        .pattern_line      (pattern_line),
        .colors            (colors),
        .r                 (r),
        .g                 (g),
        .b                 (b),
        .hsync             (hsync),
        .vsync             (vsync)
    );

endmodule

`default_nettype wire

/* source/gpu_pixel_pipe.sv */
//####################################################################
// three-stage per-pixel read pipeline: nametable lookup, pattern line
// lookup with flips, then pixel select and colour mapping
// sync levels ride a delay line of the same length as the pixels
//####################################################################
`timescale 1ns/1ps
`default_nettype none

`include "gpu_cfg.svh"

module gpu_pixel_pipe_m
    import gpu_pkg::*;
(
    input  wire logic          clk,
    input  wire logic          rst,
    input  wire logic [8:0]    hc,
    input  wire logic [9:0]    vc,
    input  wire raster_phase_e h_phase,
    input  wire raster_phase_e v_phase,
    input  wire logic          hsync_raw,
    input  wire logic          vsync_raw,
    output logic [9:0]         tile_index,
    input  wire logic [7:0]    tile_byte,
    output logic [8:0]         pattern_line_addr,
    input  wire logic [15:0]   pattern_line,
    input  wire logic [7:0]    colors,
    output logic [1:0]         r,
    output logic [1:0]         g,
    output logic [1:0]         b,
    output logic               hsync,
    output logic               vsync
);

    localparam int LATENCY = `GPU_PIPE_LATENCY;

    logic [2:0] x_s1, tile_y_s1;
    logic       visible_s1;
    logic [2:0] x_s2, color_s2;
    logic       visible_s2;
    logic       hflip, vflip;
    logic [2:0] line;
    logic [15:0] shifted;
    logic [1:0] pixel;
    logic [LATENCY-1:0] hsync_dly, vsync_dly;

    // stage 0: picture line is vc/2, so row and tile_y skip vc[0]
    assign tile_index = {vc[8:4], hc[7:3]};

    always_ff @(posedge clk) begin
        x_s1      <= hc[2:0];
        tile_y_s1 <= vc[3:1];
    end

    always_ff @(posedge clk) begin
        if (rst)
            visible_s1 <= 1'b0;
        else
            visible_s1 <= (h_phase == visible) && (v_phase == visible);
    end

    // stage 1: tile byte is {colour select, hflip, vflip, pattern[4:0]}
    assign hflip = tile_byte[6];
    assign vflip = tile_byte[5];
    assign line  = vflip ? ~tile_y_s1 : tile_y_s1;
    assign pattern_line_addr = {tile_byte[4:0], line, 1'b0};

    always_ff @(posedge clk) begin
        x_s2     <= hflip ? ~x_s1 : x_s1;
        color_s2 <= tile_byte[7] ? colors[5:3] : colors[2:0];
    end

    always_ff @(posedge clk) begin
        if (rst)
            visible_s2 <= 1'b0;
        else
            visible_s2 <= visible_s1;
    end

    // stage 2: leftmost pixel sits in bits 15:14
    assign shifted = pattern_line << {x_s2, 1'b0};
    assign pixel   = shifted[15:14];

    always_ff @(posedge clk) begin
        if (rst) begin
            r <= '0;
            g <= '0;
            b <= '0;
        end else begin
            r <= (visible_s2 && color_s2[0]) ? pixel : 2'b00;
            g <= (visible_s2 && color_s2[1]) ? pixel : 2'b00;
            b <= (visible_s2 && color_s2[2]) ? pixel : 2'b00;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            hsync_dly <= '1;
            vsync_dly <= '1;
        end else begin
            hsync_dly <= {hsync_dly[LATENCY-2:0], hsync_raw};
            vsync_dly <= {vsync_dly[LATENCY-2:0], vsync_raw};
        end
    end

    assign hsync = hsync_dly[LATENCY-1];
    assign vsync = vsync_dly[LATENCY-1];

endmodule

`default_nettype wire

/* source/gpu_vram.sv */
//####################################################################
// video memory: 512-byte background pattern store and 1024-byte
// nametable, filled by single-cycle host strobes on data/address/cs
// one nametable byte and one pattern line are read per clock, both
// registered; colors shadows nametable entry 960
//####################################################################
`timescale 1ns/1ps
`default_nettype none

`include "gpu_cfg.svh"

module gpu_vram_m
    import gpu_pkg::*;
(
    input  wire logic                        clk,
    input  wire logic [7:0]                  data,
    input  wire logic [`VRAM_ADDR_WIDTH-1:0] address,
    input  wire logic                        cs,
    input  wire logic [9:0]                  tile_index,
    output logic [7:0]                       tile_byte,
    input  wire logic [8:0]                  pattern_line_addr,
    output logic [15:0]                      pattern_line,
    output logic [7:0]                       colors
);

    logic [7:0] pmb  [`GPU_PMB_BYTES];
    logic [7:0] ntbl [`GPU_NTBL_BYTES];

    vram_region_e region;
    logic [8:0]   pmb_index;
    logic [9:0]   ntbl_index;

    always_comb begin
        if (int'(address) >= `GPU_PMB_BASE &&
            int'(address) < `GPU_PMB_BASE + `GPU_PMB_BYTES)
            region = region_pmb;
        else if (int'(address) >= `GPU_NTBL_BASE &&
                 int'(address) < `GPU_NTBL_BASE + `GPU_NTBL_BYTES)
            region = region_ntbl;
        else
            region = region_none;
    end

    assign pmb_index  = 9'(int'(address) - `GPU_PMB_BASE);
    assign ntbl_index = 10'(int'(address) - `GPU_NTBL_BASE);

    // host writes land on the next edge even during reset
    always_ff @(posedge clk) begin
        if (cs && region == region_pmb)
            pmb[pmb_index] <= data;
        if (cs && region == region_ntbl)
            ntbl[ntbl_index] <= data;
    end

    // colour byte kept outside the array so the pipeline reads it any time
    always_ff @(posedge clk) begin
        if (cs && region == region_ntbl && int'(ntbl_index) == `GPU_NTBL_COLORS_INDEX)
            colors <= data;
    end

    // even byte is the high half of the line
    always_ff @(posedge clk) begin
        tile_byte    <= ntbl[tile_index];
        pattern_line <= {pmb[pattern_line_addr], pmb[{pattern_line_addr[8:1], 1'b1}]};
    end

    line_addr_even: assert property (@(posedge clk)
        pattern_line_addr[0] == 1'b0);

    // unmapped writes must not alias into either array
    none_keeps_pmb: assert property (@(posedge clk)
        (cs && int'(address) >= `GPU_NTBL_BASE + `GPU_NTBL_BYTES)
        |=> pmb[$past(pmb_index)] == $past(pmb[pmb_index]));

    none_keeps_ntbl: assert property (@(posedge clk)
        (cs && int'(address) >= `GPU_NTBL_BASE + `GPU_NTBL_BYTES)
        |=> ntbl[$past(ntbl_index)] == $past(ntbl[ntbl_index]));

endmodule

`default_nettype wire

/* source/gpu_counters.sv */
//####################################################################
// free-running raster counters for the 400 x 525 frame
// hc and vc feed the pixel pipeline together with the decoded phase
// of each axis and the undelayed active-low sync levels
//####################################################################
`timescale 1ns/1ps
`default_nettype none

`include "gpu_cfg.svh"

module gpu_counters_m
    import gpu_pkg::*;
(
    input  wire logic   clk,
    input  wire logic   rst,
    output logic [8:0]  hc,
    output logic [9:0]  vc,
    output raster_phase_e h_phase,
    output raster_phase_e v_phase,
    output logic        hsync_raw,
    output logic        vsync_raw
);

    localparam logic [8:0] H_LAST = 9'(`GPU_CLOCKS_PER_LINE - 1);
    localparam logic [9:0] V_LAST = 10'(`GPU_LINES_PER_FRAME - 1);

    always_ff @(posedge clk) begin
        if (rst) begin
            hc <= '0;
            vc <= '0;
        end else if (hc == H_LAST) begin
            hc <= '0;
            vc <= (vc == V_LAST) ? '0 : vc + 10'd1;
        end else begin
            hc <= hc + 9'd1;
        end
    end

    always_comb begin
        if (int'(hc) < `GPU_H_VISIBLE)
            h_phase = visible;
        else if (int'(hc) < `GPU_H_BORDER_END)
            h_phase = border;
        else if (int'(hc) < `GPU_H_SYNC_START)
            h_phase = front_porch;
        else if (int'(hc) < `GPU_H_SYNC_END)
            h_phase = sync;
        else
            h_phase = back_porch;
    end

    // no vertical border, the picture runs straight into the porch
    always_comb begin
        if (int'(vc) < `GPU_V_VISIBLE)
            v_phase = visible;
        else if (int'(vc) < `GPU_V_SYNC_START)
            v_phase = front_porch;
        else if (int'(vc) < `GPU_V_SYNC_END)
            v_phase = sync;
        else
            v_phase = back_porch;
    end

    assign hsync_raw = (h_phase != sync);
    assign vsync_raw = (v_phase != sync);

    hc_in_range: assert property (@(posedge clk) disable iff (rst)
        hc <= H_LAST);

    // line count moves only on the last clock of a line
    vc_steps_at_wrap: assert property (@(posedge clk) disable iff (rst)
        (hc != H_LAST) |=> $stable(vc));

endmodule

`default_nettype wire

/* source/gpu_pkg.sv */
//####################################################################
// shared types of the tile background generator
// import with gpu_pkg::* in the module header
//####################################################################
`default_nettype none

package gpu_pkg;

    // phase of one raster axis; the vertical axis has no border
    typedef enum logic [2:0] {
        visible,
        border,
        front_porch,
        sync,
        back_porch
    } raster_phase_e;

    // decode of a host write address
    typedef enum logic [1:0] {
        region_pmb,
        region_ntbl,
        region_none
    } vram_region_e;

endpackage

`default_nettype wire

/* source/gpu_cfg.svh */
//####################################################################
// raster timing, memory sizes and host address map for the tile
// background generator; include after the net type line of any file
// that needs a boundary, a size or the VRAM address width
//####################################################################
`ifndef GPU_CFG_SVH
`define GPU_CFG_SVH

// raster totals at the 12.5875 MHz pixel clock
`define GPU_CLOCKS_PER_LINE     400
`define GPU_LINES_PER_FRAME     525

// horizontal boundaries, in clocks
`define GPU_H_VISIBLE           256
`define GPU_H_BORDER_END        320
`define GPU_H_SYNC_START        328
`define GPU_H_SYNC_END          376

// vertical boundaries, in lines
`define GPU_V_VISIBLE           480
`define GPU_V_SYNC_START        490
`define GPU_V_SYNC_END          492

// counter position to pixel on r, g and b
`define GPU_PIPE_LATENCY        3

// host address map
`define VRAM_ADDR_WIDTH         11
`define GPU_PMB_BASE            'h000
`define GPU_PMB_BYTES           512
`define GPU_NTBL_BASE           'h200
`define GPU_NTBL_BYTES          1024
`define GPU_NTBL_COLORS_INDEX   960

`endif
